//--- hdl/csi2_rx_settings.svh
`ifndef CSI2_RX_SETTINGS_SVH
`define CSI2_RX_SETTINGS_SVH

`define CSI2_EVT_DEPTH   4

`define CSI2_REG_STATUS  8'h00
`define CSI2_REG_SHORT   8'h04
`define CSI2_REG_LONG    8'h08
`define CSI2_REG_PKTCNT  8'h0C
`define CSI2_REG_ERRCNT  8'h10

`define CSI2_CRC_INIT    16'hFFFF
`define CSI2_CRC_POLY    16'h8408
`define CSI2_LONG_DT_MIN 6'h10

`endif

//--- hdl/csi2_rx_pkg.sv
package csi2_rx_pkg;

// raw header word as it arrives on the merged lanes
typedef struct packed {
  logic [7 : 0]  ecc;
  logic [15 : 0] wc;
  logic [7 : 0]  di;
} hdr_word_t;

typedef struct packed {
  logic corrected;
  logic uncorrectable;
} ecc_status_t;

// same bit order as the header, so register reads line up with the wire format
typedef struct packed {
  logic [15 : 0] data_field;
  logic [1 : 0]  vc;
  logic [5 : 0]  dt;
} short_pkt_t;

// word_cnt includes the two crc bytes
typedef struct packed {
  logic [15 : 0] word_cnt;
  logic [1 : 0]  vc;
  logic [5 : 0]  dt;
} long_hdr_t;

typedef struct packed {
  logic          eop;
  logic [3 : 0]  be;
  logic [31 : 0] data;
} payload_beat_t;

endpackage

//--- hdl/csi2_header_ecc.sv
`timescale 1ns/10ps

module csi2_header_ecc
(
  input  csi2_rx_pkg::hdr_word_t   hdr_i,
  output csi2_rx_pkg::hdr_word_t   hdr_o,
  output csi2_rx_pkg::ecc_status_t status_o
);

// parity column of each header data bit, P5 in the msb
localparam logic [5 : 0] ECC_COL [24] = '{
  6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
  6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
  6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
};

logic [23 : 0] data_raw;
logic [23 : 0] data_fix;
logic [5 : 0]  calc;
logic [5 : 0]  syndrome;
logic [5 : 0]  ecc_fix;
logic          hit;
logic          parity_err;

assign data_raw = hdr_i[23 : 0];

always_comb
begin
  calc = 6'd0;
  for( int i = 0; i < 24; i++ )
    if( data_raw[i] )
      calc = calc ^ ECC_COL[i];
end

assign syndrome = calc ^ hdr_i.ecc[5 : 0];

always_comb
begin
  data_fix = data_raw;
  hit      = 1'b0;
  for( int i = 0; i < 24; i++ )
    if( syndrome == ECC_COL[i] )
    begin
      data_fix[i] = ~data_raw[i];
      hit         = 1'b1;
    end
end

// a lone syndrome bit means the ecc byte itself took the hit
assign parity_err = $onehot( syndrome );
assign ecc_fix    = parity_err ? calc : hdr_i.ecc[5 : 0];

assign hdr_o    = { 2'b00, ecc_fix, data_fix };
assign status_o = '{
  corrected:     ( hit || parity_err ),
  uncorrectable: ( syndrome != 6'd0 ) && !hit && !parity_err
};

endmodule

//--- hdl/csi2_pkt_handler.sv
`timescale 1ns/10ps
`include "csi2_rx_settings.svh"

module csi2_pkt_handler
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  csi2_rx_pkg::hdr_word_t     hdr_i,
  input  csi2_rx_pkg::ecc_status_t   ecc_i,
  input  logic [31 : 0]              data_i,
  output csi2_rx_pkg::short_pkt_t    short_o,
  output logic                       short_valid_o,
  output csi2_rx_pkg::long_hdr_t     long_hdr_o,
  output logic                       long_valid_o,
  output csi2_rx_pkg::payload_beat_t beat_o,
  output logic                       beat_valid_o,
  output logic                       hdr_corrected_o,
  output logic                       hdr_dropped_o
);

logic          valid_d1;
logic          running;
logic          hdr_seen;
logic          hdr_ok;
logic          is_long;
logic          last_word;
logic          pkt_done;
logic          done_d1;
logic [15 : 0] byte_cnt;
logic [3 : 0]  last_be;
logic [31 : 0] beat_data;
logic [3 : 0]  beat_be;
logic          beat_eop;

// header is the first word of a burst while no long packet is open
assign hdr_seen = valid_i && !valid_d1 && !running;
assign hdr_ok   = hdr_seen && !ecc_i.uncorrectable;
assign is_long  = hdr_i.di[5 : 0] >= `CSI2_LONG_DT_MIN;

always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    valid_d1        <= 1'b0;
    done_d1         <= 1'b0;
    short_valid_o   <= 1'b0;
    hdr_corrected_o <= 1'b0;
    hdr_dropped_o   <= 1'b0;
  end
  else
  begin
    valid_d1        <= valid_i;
    done_d1         <= pkt_done;
    short_valid_o   <= hdr_ok && !is_long;
    hdr_corrected_o <= hdr_ok && ecc_i.corrected;
    hdr_dropped_o   <= hdr_seen && ecc_i.uncorrectable;
  end
end

always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    running      <= 1'b0;
    long_valid_o <= 1'b0;
  end
  else if( hdr_ok && is_long )
  begin
    running      <= 1'b1;
    long_valid_o <= 1'b1;
  end
  else
  begin
    if( pkt_done )
      running <= 1'b0;
    if( done_d1 )
      long_valid_o <= 1'b0;
  end
end

always_ff @( posedge clk_i )
begin
  if( hdr_ok && !is_long )
    short_o <= '{ data_field: hdr_i.wc, vc: hdr_i.di[7 : 6], dt: hdr_i.di[5 : 0] };
  if( hdr_ok && is_long )
    long_hdr_o <= '{ word_cnt: hdr_i.wc + 16'd2, vc: hdr_i.di[7 : 6], dt: hdr_i.di[5 : 0] };
end

// payload bytes counted in steps of four against word count plus crc
always_ff @( posedge clk_i )
begin
  if( rst_i || pkt_done )
    byte_cnt <= 16'd0;
  else if( valid_i && running )
    byte_cnt <= byte_cnt + 16'd4;
end

assign last_word = ( byte_cnt + 16'd4 ) >= long_hdr_o.word_cnt;
assign pkt_done  = last_word && running && valid_i;

always_comb
begin
  case( long_hdr_o.word_cnt[1 : 0] )
    2'd1:    last_be = 4'b0001;
    2'd2:    last_be = 4'b0011;
    2'd3:    last_be = 4'b0111;
    default: last_be = 4'b1111;
  endcase
end

always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    beat_valid_o <= 1'b0;
    beat_be      <= 4'd0;
    beat_eop     <= 1'b0;
  end
  else
  begin
    beat_valid_o <= valid_i && running;
    beat_be      <= pkt_done ? last_be : 4'b1111;
    beat_eop     <= pkt_done;
  end
end

always_ff @( posedge clk_i )
  beat_data <= data_i;

assign beat_o = '{ eop: beat_eop, be: beat_be, data: beat_data };

endmodule

//--- hdl/csi2_payload_crc.sv
`timescale 1ns/10ps
`include "csi2_rx_settings.svh"

module csi2_payload_crc
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  csi2_rx_pkg::payload_beat_t beat_i,
  input  logic                       beat_valid_i,
  output logic                       crc_done_o,
  output logic                       crc_err_o
);

logic [15 : 0] crc_q;
logic [15 : 0] crc_n;
// [7:0] holds the older byte of the window
logic [15 : 0] win_q;
logic [15 : 0] win_n;
logic [1 : 0]  fill_q;
logic [1 : 0]  fill_n;

// reflected crc-16, lsb of each byte first
function automatic logic [15 : 0] crc_byte( input logic [15 : 0] crc, input logic [7 : 0] b );
  logic [15 : 0] c;
  c = crc;
  for( int k = 0; k < 8; k++ )
    if( c[0] ^ b[k] )
      c = ( c >> 1 ) ^ `CSI2_CRC_POLY;
    else
      c = c >> 1;
  return c;
endfunction

always_comb
begin
  crc_n  = crc_q;
  win_n  = win_q;
  fill_n = fill_q;
  for( int i = 0; i < 4; i++ )
    if( beat_i.be[i] )
    begin
      // the byte falling out of the window is known to be payload
      if( fill_n == 2'd2 )
        crc_n = crc_byte( crc_n, win_n[7 : 0] );
      win_n  = { beat_i.data[8 * i +: 8], win_n[15 : 8] };
      fill_n = ( fill_n == 2'd2 ) ? 2'd2 : fill_n + 2'd1;
    end
end

always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    crc_q      <= `CSI2_CRC_INIT;
    fill_q     <= 2'd0;
    crc_done_o <= 1'b0;
    crc_err_o  <= 1'b0;
  end
  else
  begin
    crc_done_o <= beat_valid_i && beat_i.eop;
    crc_err_o  <= beat_valid_i && beat_i.eop && ( crc_n != win_n );
    if( beat_valid_i && beat_i.eop )
    begin
      crc_q  <= `CSI2_CRC_INIT;
      fill_q <= 2'd0;
    end
    else if( beat_valid_i )
    begin
      crc_q  <= crc_n;
      fill_q <= fill_n;
    end
  end
end

always_ff @( posedge clk_i )
  if( beat_valid_i )
    win_q <= win_n;

endmodule

//--- hdl/csi2_evt_fifo.sv
`timescale 1ns/10ps

module csi2_evt_fifo
#(
  parameter type entry_t = logic [23 : 0],
  parameter int  DEPTH   = 4
)
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  entry_t entry_i,
  input  logic   pop_i,
  output entry_t head_o,
  output logic   empty_o,
  output logic   overflow_o,
  input  logic   clr_ovf_i
);

localparam int AW = ( DEPTH > 1 ) ? $clog2( DEPTH ) : 1;

entry_t          mem [DEPTH];
logic [AW - 1:0] wr_ptr;
logic [AW - 1:0] rd_ptr;
logic [AW : 0]   count;
logic            full;
logic            do_pop;
logic            do_push;

assign empty_o = ( count == '0 );
assign full    = ( count == ( AW + 1 )'( DEPTH ) );
assign do_pop  = pop_i && !empty_o;
// a pop in the same cycle makes room for the push
assign do_push = push_i && ( !full || do_pop );
assign head_o  = mem[rd_ptr];

always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    for( int i = 0; i < DEPTH; i++ )
      mem[i] <= '0;
    wr_ptr     <= '0;
    rd_ptr     <= '0;
    count      <= '0;
    overflow_o <= 1'b0;
  end
  else
  begin
    if( do_push )
    begin
      mem[wr_ptr] <= entry_i;
      wr_ptr      <= ( wr_ptr == AW'( DEPTH - 1 ) ) ? '0 : wr_ptr + 1'b1;
    end
    if( do_pop )
      rd_ptr <= ( rd_ptr == AW'( DEPTH - 1 ) ) ? '0 : rd_ptr + 1'b1;
    count <= count + ( AW + 1 )'( do_push ) - ( AW + 1 )'( do_pop );
    if( push_i && !do_push )
      overflow_o <= 1'b1;
    else if( clr_ovf_i )
      overflow_o <= 1'b0;
  end
end

endmodule

//--- hdl/csi2_wb_regs.sv
`timescale 1ns/10ps
`include "csi2_rx_settings.svh"

module csi2_wb_regs
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [7 : 0]            wb_adr_i,
  input  logic [31 : 0]           wb_dat_i,
  output logic [31 : 0]           wb_dat_o,
  output logic                    wb_ack_o,
  input  csi2_rx_pkg::short_pkt_t short_head_i,
  input  csi2_rx_pkg::long_hdr_t  long_head_i,
  input  logic                    short_empty_i,
  input  logic                    long_empty_i,
  input  logic                    short_ovf_i,
  input  logic                    long_ovf_i,
  input  logic                    short_evt_i,
  input  logic                    long_evt_i,
  input  logic                    hdr_corrected_i,
  input  logic                    hdr_dropped_i,
  input  logic                    crc_done_i,
  input  logic                    crc_err_i,
  output logic                    short_pop_o,
  output logic                    long_pop_o,
  output logic [1 : 0]            clr_ovf_o
);

logic [15 : 0] short_cnt;
logic [15 : 0] long_cnt;
logic [7 : 0]  corr_cnt;
logic [7 : 0]  drop_cnt;
logic [7 : 0]  crc_cnt;
logic [31 : 0] rd_data;
logic          req;
logic          rd_ack;
logic          wr_ack;

assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
assign rd_ack = wb_ack_o && !wb_we_i;
assign wr_ack = wb_ack_o && wb_we_i;

always_comb
begin
  case( wb_adr_i )
    `CSI2_REG_STATUS: rd_data = { 28'd0, long_ovf_i, short_ovf_i, !long_empty_i, !short_empty_i };
    `CSI2_REG_SHORT:  rd_data = { 8'd0, short_head_i };
    `CSI2_REG_LONG:   rd_data = { 8'd0, long_head_i };
    `CSI2_REG_PKTCNT: rd_data = { long_cnt, short_cnt };
    `CSI2_REG_ERRCNT: rd_data = { 8'd0, crc_cnt, drop_cnt, corr_cnt };
    default:          rd_data = 32'd0;
  endcase
end

always_ff @( posedge clk_i )
begin
  if( rst_i )
    wb_ack_o <= 1'b0;
  else
    wb_ack_o <= req;
end

always_ff @( posedge clk_i )
  if( req )
    wb_dat_o <= rd_data;

// head was sampled into wb_dat_o, so the pop lands on the ack cycle
assign short_pop_o = rd_ack && ( wb_adr_i == `CSI2_REG_SHORT );
assign long_pop_o  = rd_ack && ( wb_adr_i == `CSI2_REG_LONG );
assign clr_ovf_o   = ( wr_ack && ( wb_adr_i == `CSI2_REG_STATUS ) ) ? wb_dat_i[3 : 2] : 2'b00;

// saturating counters
always_ff @( posedge clk_i )
begin
  if( rst_i )
  begin
    short_cnt <= 16'd0;
    long_cnt  <= 16'd0;
    corr_cnt  <= 8'd0;
    drop_cnt  <= 8'd0;
    crc_cnt   <= 8'd0;
  end
  else
  begin
    if( short_evt_i && ( short_cnt != 16'hFFFF ) )
      short_cnt <= short_cnt + 16'd1;
    if( long_evt_i && ( long_cnt != 16'hFFFF ) )
      long_cnt <= long_cnt + 16'd1;
    if( hdr_corrected_i && ( corr_cnt != 8'hFF ) )
      corr_cnt <= corr_cnt + 8'd1;
    if( hdr_dropped_i && ( drop_cnt != 8'hFF ) )
      drop_cnt <= drop_cnt + 8'd1;
    if( crc_done_i && crc_err_i && ( crc_cnt != 8'hFF ) )
      crc_cnt <= crc_cnt + 8'd1;
  end
end

endmodule

//--- hdl/csi2_rx_top.sv
`timescale 1ns/10ps
`include "csi2_rx_settings.svh"

module csi2_rx_top
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [31 : 0]              data_i,
  output csi2_rx_pkg::payload_beat_t beat_o,
  output logic                       beat_valid_o,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [7 : 0]               wb_adr_i,
  input  logic [31 : 0]              wb_dat_i,
  output logic [31 : 0]              wb_dat_o,
  output logic                       wb_ack_o
);

csi2_rx_pkg::hdr_word_t   hdr_fix;
csi2_rx_pkg::ecc_status_t ecc_status;
csi2_rx_pkg::short_pkt_t  short_evt;
csi2_rx_pkg::short_pkt_t  short_head;
csi2_rx_pkg::long_hdr_t   long_evt;
csi2_rx_pkg::long_hdr_t   long_head;
logic                     short_valid;
logic                     long_valid;
logic                     long_valid_q;
logic                     long_push;
logic                     hdr_corrected;
logic                     hdr_dropped;
logic                     crc_done;
logic                     crc_err;
logic                     short_empty;
logic                     long_empty;
logic                     short_ovf;
logic                     long_ovf;
logic                     short_pop;
logic                     long_pop;
logic [1 : 0]             clr_ovf;

csi2_header_ecc u_ecc
(
  .hdr_i    ( data_i     ),
  .hdr_o    ( hdr_fix    ),
  .status_o ( ecc_status )
);

csi2_pkt_handler u_handler
(
  .clk_i           ( clk_i         ),
  .rst_i           ( rst_i         ),
  .valid_i         ( valid_i       ),
  .hdr_i           ( hdr_fix       ),
  .ecc_i           ( ecc_status    ),
  .data_i          ( data_i        ),
  .short_o         ( short_evt     ),
  .short_valid_o   ( short_valid   ),
  .long_hdr_o      ( long_evt      ),
  .long_valid_o    ( long_valid    ),
  .beat_o          ( beat_o        ),
  .beat_valid_o    ( beat_valid_o  ),
  .hdr_corrected_o ( hdr_corrected ),
  .hdr_dropped_o   ( hdr_dropped   )
);

csi2_payload_crc u_crc
(
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .beat_i       ( beat_o       ),
  .beat_valid_i ( beat_valid_o ),
  .crc_done_o   ( crc_done     ),
  .crc_err_o    ( crc_err      )
);

// long header valid spans the packet, queue it once
always_ff @( posedge clk_i )
begin
  if( rst_i )
    long_valid_q <= 1'b0;
  else
    long_valid_q <= long_valid;
end

assign long_push = long_valid && !long_valid_q;

csi2_evt_fifo #( .entry_t( csi2_rx_pkg::short_pkt_t ), .DEPTH( `CSI2_EVT_DEPTH ) ) u_short_q
(
  .clk_i      ( clk_i       ),
  .rst_i      ( rst_i       ),
  .push_i     ( short_valid ),
  .entry_i    ( short_evt   ),
  .pop_i      ( short_pop   ),
  .head_o     ( short_head  ),
  .empty_o    ( short_empty ),
  .overflow_o ( short_ovf   ),
  .clr_ovf_i  ( clr_ovf[0]  )
);

csi2_evt_fifo #( .entry_t( csi2_rx_pkg::long_hdr_t ), .DEPTH( `CSI2_EVT_DEPTH ) ) u_long_q
(
  .clk_i      ( clk_i      ),
  .rst_i      ( rst_i      ),
  .push_i     ( long_push  ),
  .entry_i    ( long_evt   ),
  .pop_i      ( long_pop   ),
  .head_o     ( long_head  ),
  .empty_o    ( long_empty ),
  .overflow_o ( long_ovf   ),
  .clr_ovf_i  ( clr_ovf[1] )
);

csi2_wb_regs u_regs
(
  .clk_i           ( clk_i         ),
  .rst_i           ( rst_i         ),
  .wb_cyc_i        ( wb_cyc_i      ),
  .wb_stb_i        ( wb_stb_i      ),
  .wb_we_i         ( wb_we_i       ),
  .wb_adr_i        ( wb_adr_i      ),
  .wb_dat_i        ( wb_dat_i      ),
  .wb_dat_o        ( wb_dat_o      ),
  .wb_ack_o        ( wb_ack_o      ),
  .short_head_i    ( short_head    ),
  .long_head_i     ( long_head     ),
  .short_empty_i   ( short_empty   ),
  .long_empty_i    ( long_empty    ),
  .short_ovf_i     ( short_ovf     ),
  .long_ovf_i      ( long_ovf      ),
  .short_evt_i     ( short_valid   ),
  .long_evt_i      ( long_push     ),
  .hdr_corrected_i ( hdr_corrected ),
  .hdr_dropped_i   ( hdr_dropped   ),
  .crc_done_i      ( crc_done      ),
  .crc_err_i       ( crc_err       ),
  .short_pop_o     ( short_pop     ),
  .long_pop_o      ( long_pop      ),
  .clr_ovf_o       ( clr_ovf       )
);

endmodule

//--- verification/csi2_rx_sva.sv
`timescale 1ns/10ps

module csi2_rx_sva
(
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       cyc_i,
  input logic                       stb_i,
  input logic                       ack_i,
  input csi2_rx_pkg::payload_beat_t beat_i,
  input logic                       beat_valid_i,
  input logic                       short_valid_i,
  input logic                       long_valid_i
);

int fail_cnt = 0;

// ack is a one-cycle pulse answering an open request
ack_single: assert property ( @( posedge clk_i ) disable iff ( rst_i ) ack_i |=> !ack_i )
else
begin
  $error( "wb_ack_o stayed high for more than one cycle" );
  fail_cnt++;
end

ack_after_req: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  ack_i |-> $past( cyc_i && stb_i ) )
else
begin
  $error( "wb_ack_o without a preceding cyc and stb" );
  fail_cnt++;
end

eop_in_beat: assert property ( @( posedge clk_i ) disable iff ( rst_i ) beat_i.eop |-> beat_valid_i )
else
begin
  $error( "eop outside a valid beat" );
  fail_cnt++;
end

idle_after_reset: assert property ( @( posedge clk_i )
  rst_i |=> !beat_valid_i && !beat_i.eop && !short_valid_i && !long_valid_i && !ack_i )
else
begin
  $error( "output valid in the cycle after reset" );
  fail_cnt++;
end

endmodule

bind csi2_rx_top csi2_rx_sva u_sva
(
  .clk_i         ( clk_i        ),
  .rst_i         ( rst_i        ),
  .cyc_i         ( wb_cyc_i     ),
  .stb_i         ( wb_stb_i     ),
  .ack_i         ( wb_ack_o     ),
  .beat_i        ( beat_o       ),
  .beat_valid_i  ( beat_valid_o ),
  .short_valid_i ( short_valid  ),
  .long_valid_i  ( long_valid   )
);

//--- verification/csi2_rx_tb.sv
`timescale 1ns/10ps
`include "csi2_rx_settings.svh"

module csi2_rx_tb;

// five tests need a few hundred cycles, so this leaves a wide margin
localparam int MAX_CYCLES = 4000;

logic                       clk_i;
logic                       rst_i;
logic                       valid_i;
logic [31 : 0]              data_i;
csi2_rx_pkg::payload_beat_t beat_o;
logic                       beat_valid_o;
logic                       wb_cyc_i;
logic                       wb_stb_i;
logic                       wb_we_i;
logic [7 : 0]               wb_adr_i;
logic [31 : 0]              wb_dat_i;
logic [31 : 0]              wb_dat_o;
logic                       wb_ack_o;

// payload plus crc trailer of the packet being sent
logic [7 : 0]               tx_bytes [$];
csi2_rx_pkg::payload_beat_t rx_beats [$];
logic                       eop_seen;
int                         cycles;
int                         errors;
int                         failed_tests;

csi2_rx_top dut
(
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .valid_i      ( valid_i      ),
  .data_i       ( data_i       ),
  .beat_o       ( beat_o       ),
  .beat_valid_o ( beat_valid_o ),
  .wb_cyc_i     ( wb_cyc_i     ),
  .wb_stb_i     ( wb_stb_i     ),
  .wb_we_i      ( wb_we_i      ),
  .wb_adr_i     ( wb_adr_i     ),
  .wb_dat_i     ( wb_dat_i     ),
  .wb_dat_o     ( wb_dat_o     ),
  .wb_ack_o     ( wb_ack_o     )
);

always #2 clk_i = ~clk_i;

always @( posedge clk_i )
begin
  cycles = cycles + 1;
  if( cycles >= MAX_CYCLES )
  begin
    $display( "timeout: the run did not finish within %0d cycles", MAX_CYCLES );
    $display( "Some tests failed" );
    $finish;
  end
end

// beats are collected away from the active edge
always @( negedge clk_i )
begin
  if( beat_valid_o )
  begin
    rx_beats.push_back( beat_o );
    if( beat_o.eop )
      eop_seen = 1'b1;
  end
end

// parity equations of the csi-2 header ecc, one mask per parity bit
function automatic logic [7 : 0] header_ecc( input logic [23 : 0] d );
  logic [23 : 0] mask [6];
  logic [7 : 0]  p;
  mask = '{ 24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00 };
  p    = 8'd0;
  for( int i = 0; i < 6; i++ )
    p[i] = ^( d & mask[i] );
  return p;
endfunction

function automatic logic [15 : 0] crc16_update( input logic [15 : 0] crc, input logic [7 : 0] b );
  logic [15 : 0] c;
  c = crc ^ { 8'd0, b };
  for( int k = 0; k < 8; k++ )
    c = c[0] ? ( ( c >> 1 ) ^ `CSI2_CRC_POLY ) : ( c >> 1 );
  return c;
endfunction

task automatic check_value( input string name, input logic [63 : 0] got,
                            input logic [63 : 0] want );
  assert( got === want )
  else
  begin
    $display( "** Error %s: got 0x%0h, expected 0x%0h", name, got, want );
    errors = errors + 1;
  end
endtask

task automatic build_payload( input int n, input bit bad_crc );
  logic [15 : 0] crc;
  logic [7 : 0]  b;
  tx_bytes.delete();
  crc = `CSI2_CRC_INIT;
  for( int i = 0; i < n; i++ )
  begin
    b = 8'( $urandom );
    tx_bytes.push_back( b );
    crc = crc16_update( crc, b );
  end
  if( bad_crc )
    crc[0] = ~crc[0];
  // trailer goes out low byte first
  tx_bytes.push_back( crc[7 : 0] );
  tx_bytes.push_back( crc[15 : 8] );
endtask

task automatic send_packet( input logic [7 : 0] di, input logic [15 : 0] wc,
                            input logic [23 : 0] flip );
  logic [23 : 0] d;
  logic [31 : 0] w;
  int            nw;
  d  = { wc, di };
  nw = ( tx_bytes.size() + 3 ) / 4;
  @( posedge clk_i );
  #1;
  valid_i = 1'b1;
  data_i  = { header_ecc( d ), d ^ flip };
  for( int i = 0; i < nw; i++ )
  begin
    w = 32'd0;
    for( int j = 0; j < 4; j++ )
      if( 4 * i + j < tx_bytes.size() )
        w[8 * j +: 8] = tx_bytes[4 * i + j];
    @( posedge clk_i );
    #1;
    data_i = w;
  end
  @( posedge clk_i );
  #1;
  valid_i = 1'b0;
  data_i  = 32'd0;
endtask

task automatic wait_packet_end();
  while( !eop_seen )
    @( negedge clk_i );
  // crc result lands one cycle after the eop beat
  @( negedge clk_i );
endtask

task automatic check_beats();
  csi2_rx_pkg::payload_beat_t want;
  int                         nw;
  int                         rem;
  nw  = ( tx_bytes.size() + 3 ) / 4;
  rem = tx_bytes.size() % 4;
  check_value( "beat count", rx_beats.size(), nw );
  for( int i = 0; i < nw && i < rx_beats.size(); i++ )
  begin
    want = '0;
    for( int j = 0; j < 4; j++ )
      if( 4 * i + j < tx_bytes.size() )
        want.data[8 * j +: 8] = tx_bytes[4 * i + j];
    want.eop = ( i == nw - 1 );
    want.be  = ( want.eop && rem != 0 ) ? 4'( ( 1 << rem ) - 1 ) : 4'hF;
    check_value( "beat_o", rx_beats[i], want );
  end
endtask

task automatic wb_access( input logic we, input logic [7 : 0] adr, input logic [31 : 0] wdat,
                          output logic [31 : 0] rdat );
  @( posedge clk_i );
  #1;
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = we;
  wb_adr_i = adr;
  wb_dat_i = wdat;
  do
    @( negedge clk_i );
  while( !wb_ack_o );
  rdat = wb_dat_o;
  @( posedge clk_i );
  #1;
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

task automatic reg_read( input logic [7 : 0] adr, input logic [31 : 0] want, input string name );
  logic [31 : 0] got;
  wb_access( 1'b0, adr, 32'd0, got );
  check_value( name, got, want );
endtask

task automatic end_test( input string name, input int errs_before );
  if( errors == errs_before )
    $display( "%s: ok", name );
  else
  begin
    $display( "%s: %0d check(s) failed", name, errors - errs_before );
    failed_tests = failed_tests + 1;
  end
endtask

initial
begin
  csi2_rx_pkg::short_pkt_t sp;
  csi2_rx_pkg::long_hdr_t  lh;
  logic [31 : 0]           rd;
  logic [15 : 0]           wc;
  int                      mark;
  void'( $urandom( 95 ) );
  clk_i        = 1'b0;
  rst_i        = 1'b1;
  valid_i      = 1'b0;
  data_i       = 32'd0;
  wb_cyc_i     = 1'b0;
  wb_stb_i     = 1'b0;
  wb_we_i      = 1'b0;
  wb_adr_i     = 8'd0;
  wb_dat_i     = 32'd0;
  eop_seen     = 1'b0;
  cycles       = 0;
  errors       = 0;
  failed_tests = 0;
  repeat( 3 ) @( posedge clk_i );
  #1;
  rst_i = 1'b0;

  mark = errors;
  tx_bytes.delete();
  sp = '{ data_field: 16'h1234, vc: 2'd1, dt: 6'h02 };
  send_packet( { 2'd1, 6'h02 }, 16'h1234, 24'd0 );
  reg_read( `CSI2_REG_SHORT, { 8'd0, sp }, "SHORT" );
  reg_read( `CSI2_REG_PKTCNT, { 16'd0, 16'd1 }, "PKTCNT" );
  end_test( "test 1 short packet", mark );

  mark = errors;
  wc   = 16'( $urandom_range( 40, 1 ) );
  build_payload( wc, 1'b0 );
  rx_beats.delete();
  eop_seen = 1'b0;
  send_packet( { 2'd2, 6'h2A }, wc, 24'd0 );
  wait_packet_end();
  check_beats();
  lh = '{ word_cnt: wc + 16'd2, vc: 2'd2, dt: 6'h2A };
  reg_read( `CSI2_REG_LONG, { 8'd0, lh }, "LONG" );
  reg_read( `CSI2_REG_PKTCNT, { 16'd1, 16'd1 }, "PKTCNT" );
  wb_access( 1'b0, `CSI2_REG_ERRCNT, 32'd0, rd );
  check_value( "ERRCNT[23:16]", rd[23 : 16], 8'd0 );
  end_test( "test 2 long packet", mark );

  mark = errors;
  tx_bytes.delete();
  sp = '{ data_field: 16'hBEEF, vc: 2'd0, dt: 6'h03 };
  send_packet( { 2'd0, 6'h03 }, 16'hBEEF, 24'h000020 );
  reg_read( `CSI2_REG_SHORT, { 8'd0, sp }, "SHORT" );
  // two flips in a long header, its payload must be ignored too
  build_payload( 8, 1'b0 );
  rx_beats.delete();
  send_packet( { 2'd0, 6'h2A }, 16'd8, 24'h000003 );
  reg_read( `CSI2_REG_STATUS, 32'd0, "STATUS" );
  check_value( "beat count", rx_beats.size(), 0 );
  wb_access( 1'b0, `CSI2_REG_ERRCNT, 32'd0, rd );
  check_value( "ERRCNT[7:0]", rd[7 : 0], 8'd1 );
  check_value( "ERRCNT[15:8]", rd[15 : 8], 8'd1 );
  end_test( "test 3 header ecc", mark );

  mark = errors;
  wc   = 16'( $urandom_range( 40, 1 ) );
  build_payload( wc, 1'b1 );
  rx_beats.delete();
  eop_seen = 1'b0;
  send_packet( { 2'd0, 6'h2B }, wc, 24'd0 );
  wait_packet_end();
  wb_access( 1'b0, `CSI2_REG_ERRCNT, 32'd0, rd );
  check_value( "ERRCNT[23:16]", rd[23 : 16], 8'd1 );
  lh = '{ word_cnt: wc + 16'd2, vc: 2'd0, dt: 6'h2B };
  reg_read( `CSI2_REG_LONG, { 8'd0, lh }, "LONG" );
  end_test( "test 4 crc error", mark );

  mark = errors;
  tx_bytes.delete();
  for( int i = 0; i < 5; i++ )
    send_packet( { 2'd0, 6'h01 }, 16'h0100 + 16'( i ), 24'd0 );
  reg_read( `CSI2_REG_STATUS, 32'h5, "STATUS" );
  for( int i = 0; i < 4; i++ )
  begin
    sp = '{ data_field: 16'h0100 + 16'( i ), vc: 2'd0, dt: 6'h01 };
    reg_read( `CSI2_REG_SHORT, { 8'd0, sp }, "SHORT" );
  end
  reg_read( `CSI2_REG_STATUS, 32'h4, "STATUS" );
  wb_access( 1'b1, `CSI2_REG_STATUS, 32'hC, rd );
  reg_read( `CSI2_REG_STATUS, 32'h0, "STATUS" );
  end_test( "test 5 queue overflow", mark );

  $display( "5 tests run, %0d failed, %0d check errors, %0d assertion failures",
            failed_tests, errors, dut.u_sva.fail_cnt );
  if( errors == 0 && dut.u_sva.fail_cnt == 0 )
    $display( "All tests passed" );
  else
    $display( "Some tests failed" );
  $finish;
end

endmodule

//--- src.f
+incdir+hdl
hdl/csi2_rx_pkg.sv
hdl/csi2_header_ecc.sv
hdl/csi2_pkt_handler.sv
hdl/csi2_payload_crc.sv
hdl/csi2_evt_fifo.sv
hdl/csi2_wb_regs.sv
hdl/csi2_rx_top.sv
verification/csi2_rx_sva.sv
verification/csi2_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= csi2_rx_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
